// File: axi_response_channel.sv
/*
 * AXI write response channel controller
 * Accepts BRESP while enabled and hands it to the client
 */

module axi_response_channel (
    // From the sequencer
    input  logic                     enable,

    // AXI write response channel
    input  logic                     bvalid,
    input  axi_write_pkg::axi_resp_t bresp,
    output logic                     bready,

    // Completion towards client and buffer
    output logic                     done,
    output axi_write_pkg::axi_resp_t resp
);

    // ------------------------------------------------------------------------
    // Ready

    // Only in the response phase
    always_comb begin
        bready = enable;
    end

    // ------------------------------------------------------------------------
    // Completion

    // Transfer cycle on the B channel
    always_comb begin
        done = bready && bvalid;
    end

    // Response code passed through untouched, meaningful with done only
    always_comb begin
        resp = bresp;
    end

endmodule

// File: axi_source_channel.sv
/*
 * Outbound AXI valid/ready channel controller
 * Presents a payload while enabled and reports done on the handshake
 */

module axi_source_channel #(
    parameter type payload_t = logic
) (
    // From the sequencer
    input  logic     enable,

    // From the command buffer
    input  logic     payload_present,
    input  payload_t payload_in,

    // AXI channel
    input  logic     ready,
    output logic     valid,
    output payload_t payload_out,

    // Back to the sequencer
    output logic     done
);

    // ------------------------------------------------------------------------
    // Valid generation

    // Channel active only in its own phase with a command in the buffer.
    // Both inputs are registered and hold until the handshake, so valid
    // stays up without any local state.
    always_comb begin
        valid = enable && payload_present;
    end

    // ------------------------------------------------------------------------
    // Payload

    // Straight from the held command, stable for the whole phase
    always_comb begin
        payload_out = payload_in;
    end

    // ------------------------------------------------------------------------
    // Handshake

    // High only in the cycle the transfer happens
    always_comb begin
        done = valid && ready;
    end

endmodule

// File: axi_write_command_buffer.sv
/*
 * One-entry write command buffer
 * Holds a client command from acceptance until its write response completes
 */

module axi_write_command_buffer (
    input  logic                    clock,
    input  logic                    rst_n,

    // Client side
    input  logic                    cmd_valid,
    input  axi_write_pkg::write_cmd_t cmd,
    output logic                    cmd_ready,

    // Held command towards the channel controllers
    output logic                    cmd_held,
    output axi_write_pkg::write_cmd_t held_cmd,

    // Pulse from the response controller
    input  logic                    release_cmd
);

    // Buffer occupancy
    logic full;

    // Client may only hand over a command while empty
    logic accept;

    // ------------------------------------------------------------------------
    // Occupancy flag

    always_comb begin
        accept = cmd_valid && !full;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (release_cmd) begin
            // Response done, entry free again
            full <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Command storage

    // Loaded only on accept, stays put until the next one
    always_ff @(posedge clock) begin
        if (accept) begin
            held_cmd <= cmd;
        end
    end

    // Ready level is just the empty flag
    assign cmd_ready = !full;
    assign cmd_held  = full;

endmodule

// File: axi_write_master.sv
/*
 * AXI4-Lite write master
 * Takes one client write command at a time and runs the address, data and
 * response transactions in strict order, returning the slave's BRESP
 */

module axi_write_master (
    input  logic                        clock,
    input  logic                        rst_n,

    // Client command
    input  logic                        cmd_valid,
    input  axi_write_pkg::write_cmd_t   cmd,
    output logic                        cmd_ready,

    // Client completion
    output logic                        wr_done,
    output axi_write_pkg::axi_resp_t    wr_resp,

    // AXI write address channel
    output logic                        awvalid,
    input  logic                        awready,
    output axi_write_pkg::aw_payload_t  aw,

    // AXI write data channel
    output logic                        wvalid,
    input  logic                        wready,
    output axi_write_pkg::w_payload_t   w,

    // AXI write response channel
    input  logic                        bvalid,
    output logic                        bready,
    input  axi_write_pkg::axi_resp_t    bresp
);

    import axi_write_pkg::*;

    // ------------------------------------------------------------------------
    // Internal wiring

    // Buffered command
    write_cmd_t held_cmd;
    logic       cmd_held;

    // Sequencer enables
    logic aw_enable;
    logic w_enable;
    logic b_enable;

    // Controller dones
    logic aw_done;
    logic w_done;
    logic b_done;

    // ------------------------------------------------------------------------
    // Command buffer, freed by the response handshake

    axi_write_command_buffer buffer0 (
        .clock       (clock),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cmd_ready   (cmd_ready),
        .cmd_held    (cmd_held),
        .held_cmd    (held_cmd),
        .release_cmd (b_done)
    );

    // ------------------------------------------------------------------------
    // Phase sequencing

    axi_write_sequencer sequencer0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .aw_enable (aw_enable),
        .aw_done   (aw_done),
        .w_enable  (w_enable),
        .w_done    (w_done),
        .b_enable  (b_enable),
        .b_done    (b_done)
    );

    // ------------------------------------------------------------------------
    // Channel controllers

    // Write address
    axi_source_channel #(
        .payload_t (aw_payload_t)
    ) aw_channel0 (
        .enable          (aw_enable),
        .payload_present (cmd_held),
        .payload_in      (held_cmd.aw),
        .ready           (awready),
        .valid           (awvalid),
        .payload_out     (aw),
        .done            (aw_done)
    );

    // Write data
    axi_source_channel #(
        .payload_t (w_payload_t)
    ) w_channel0 (
        .enable          (w_enable),
        .payload_present (cmd_held),
        .payload_in      (held_cmd.w),
        .ready           (wready),
        .valid           (wvalid),
        .payload_out     (w),
        .done            (w_done)
    );

    // Write response, its done doubles as the client's completion pulse
    axi_response_channel b_channel0 (
        .enable (b_enable),
        .bvalid (bvalid),
        .bresp  (bresp),
        .bready (bready),
        .done   (b_done),
        .resp   (wr_resp)
    );

    assign wr_done = b_done;

endmodule

// File: axi_write_master_sva.sv
/*
 * Protocol assertions for the AXI4-Lite write master
 * Valid stability, one active channel at a time, client held off while busy
 */

module axi_write_master_sva (
    input logic                       clock,
    input logic                       rst_n,
    input logic                       cmd_ready,
    input logic                       awvalid,
    input logic                       awready,
    input axi_write_pkg::aw_payload_t aw,
    input logic                       wvalid,
    input logic                       wready,
    input axi_write_pkg::w_payload_t  w,
    input logic                       bready
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of assertion failures so far
    int unsigned error_count = 0;

    // Address and data held until the slave takes them
    aw_stable: assert property (@(posedge clock) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            error_count++;
            $error("awvalid or aw changed before awready");
        end

    w_stable: assert property (@(posedge clock) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            error_count++;
            $error("wvalid or w changed before wready");
        end

    // Strict channel order means one phase active
    one_channel: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0({awvalid, wvalid, bready}))
        else begin
            error_count++;
            $error("more than one write channel active");
        end

    busy_client: assert property (@(posedge clock) disable iff (!rst_n)
        (awvalid || wvalid || bready) |-> !cmd_ready)
        else begin
            error_count++;
            $error("cmd_ready high while a write is in flight");
        end

endmodule

bind axi_write_master axi_write_master_sva sva0 (
    .clock (clock), .rst_n (rst_n), .cmd_ready (cmd_ready),
    .awvalid (awvalid), .awready (awready), .aw (aw),
    .wvalid (wvalid), .wready (wready), .w (w), .bready (bready)
);

// File: axi_write_pkg.sv
/*
 * AXI4-Lite write master shared definitions
 * Bus widths, response codes, channel payloads and sequencer phases
 */

package axi_write_pkg;

    // ------------------------------------------------------------------------
    // Bus widths

    // Address and data width of the AXI4-Lite bus
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // One strobe bit per data byte
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // AWPROT width, fixed by the protocol
    localparam int PROT_WIDTH = 3;

    // ------------------------------------------------------------------------
    // Response codes as carried on BRESP

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // ------------------------------------------------------------------------
    // Channel payloads

    // Write address channel, 35 bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [PROT_WIDTH-1:0] prot;
    } aw_payload_t;

    // Write data channel, 36 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } w_payload_t;

    // Full client command, address part in the upper bits
    typedef struct packed {
        aw_payload_t aw;
        w_payload_t  w;
    } write_cmd_t;

    // ------------------------------------------------------------------------
    // Sequencer phases, one per AXI write channel

    typedef enum logic [1:0] {
        PHASE_ADDR = 2'd0,
        PHASE_DATA = 2'd1,
        PHASE_RESP = 2'd2
    } write_phase_t;

endpackage

// File: axi_write_sequencer.sv
/*
 * AXI4-Lite write sequencer
 * Enables the address, data and response channel controllers in turn,
 * stepping on the done of whichever one is currently enabled
 */

module axi_write_sequencer (
    input  logic clock,
    input  logic rst_n,

    // Write address controller
    output logic aw_enable,
    input  logic aw_done,

    // Write data controller
    output logic w_enable,
    input  logic w_done,

    // Write response controller
    output logic b_enable,
    input  logic b_done
);

    import axi_write_pkg::*;

    write_phase_t phase;
    write_phase_t phase_next;

    // Dones after masking with the matching enable
    logic aw_step;
    logic w_step;
    logic b_step;

    // ------------------------------------------------------------------------
    // Phase decode, exactly one enable high

    always_comb begin
        aw_enable = (phase == PHASE_ADDR);
        w_enable  = (phase == PHASE_DATA);
        b_enable  = (phase == PHASE_RESP);
    end

    // Ignore dones from idle controllers
    always_comb begin
        aw_step = aw_enable && aw_done;
        w_step  = w_enable  && w_done;
        b_step  = b_enable  && b_done;
    end

    // ------------------------------------------------------------------------
    // Transitions: address -> data -> response -> address

    always_comb begin
        phase_next = phase;
        case (phase)
            PHASE_ADDR: if (aw_step) phase_next = PHASE_DATA;
            PHASE_DATA: if (w_step)  phase_next = PHASE_RESP;
            PHASE_RESP: if (b_step)  phase_next = PHASE_ADDR;
            // Unused encoding falls back to the start
            default:    phase_next = PHASE_ADDR;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            phase <= PHASE_ADDR;
        end else begin
            phase <= phase_next;
        end
    end

endmodule

// File: compile.f
axi_write_pkg.sv
axi_write_sequencer.sv
axi_write_command_buffer.sv
axi_source_channel.sv
axi_response_channel.sv
axi_write_master.sv
axi_write_master_sva.sv
tb_axi_write_master.sv

// File: run.sh
#!/bin/bash
# Build and run the AXI4-Lite write master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_axi_write_master -f compile.f -o sim_tb

# Log is searched below, tee keeps it visible too
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qF -- '*** FAILED ***' sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -qF -- '*** PASSED ***' sim.log; then
    echo "Simulation ended without completing"
    exit 1
fi
echo "Simulation passed"

// File: tb_axi_write_master.sv
/*
 * Testbench for the AXI4-Lite write master
 * Table-driven client, AXI slave model with LFSR back-pressure, typed checks
 */

module tb_axi_write_master;

    timeunit 1ns;
    timeprecision 100ps;

    import axi_write_pkg::*;

    localparam int NUM_ROWS   = 8;
    localparam int WAIT_LIMIT = 50;

    // One write with its command fields and the response the slave returns
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [PROT_WIDTH-1:0] prot;
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        axi_resp_t             resp;
    } stim_row_t;

    logic        clock = 1'b0;
    logic        rst_n;
    logic        cmd_valid;
    write_cmd_t  cmd;
    logic        cmd_ready;
    logic        wr_done;
    axi_resp_t   wr_resp;
    logic        awvalid;
    logic        awready;
    aw_payload_t aw;
    logic        wvalid;
    logic        wready;
    w_payload_t  w;
    logic        bvalid;
    logic        bready;
    axi_resp_t   bresp;

    stim_row_t   rows [NUM_ROWS];
    logic [31:0] lfsr_state;

    // Slave model bookkeeping
    int   aw_count    = 0;
    int   done_count  = 0;
    logic addr_passed = 1'b0;
    logic data_passed = 1'b0;

    axi_write_master dut0 (
        .clock     (clock),     .rst_n   (rst_n),
        .cmd_valid (cmd_valid), .cmd     (cmd),     .cmd_ready (cmd_ready),
        .wr_done   (wr_done),   .wr_resp (wr_resp),
        .awvalid   (awvalid),   .awready (awready), .aw        (aw),
        .wvalid    (wvalid),    .wready  (wready),  .w         (w),
        .bvalid    (bvalid),    .bready  (bready),  .bresp     (bresp)
    );

    always #50 clock = ~clock;

    // ------------------------------------------------------------------------
    // Helpers

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_aw(string name, aw_payload_t expected, aw_payload_t actual);
        if (actual !== expected)
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_w(string name, w_payload_t expected, w_payload_t actual);
        if (actual !== expected)
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_resp(string name, axi_resp_t expected, axi_resp_t actual);
        if (actual !== expected)
            abort_run($sformatf("CHECK FAILED %s expected %s actual %s",
                                name, expected.name(), actual.name()));
    endtask

    task automatic check_level(string name, logic expected, logic actual);
        if (actual !== expected)
            abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, expected, actual));
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Stall of 0 to 3 cycles with one LFSR step per bit
    task automatic back_off();
        int cycles;
        cycles = 0;
        repeat (2) begin
            lfsr_state = lfsr_next(lfsr_state);
            cycles = (cycles << 1) | int'(lfsr_state[0]);
        end
        repeat (cycles) begin
            @(posedge clock);
            #10;
        end
    endtask

    function automatic logic handshake(int channel);
        case (channel)
            0:       return awvalid && awready;
            1:       return wvalid && wready;
            default: return bvalid && bready;
        endcase
    endfunction

    // Returns at the falling edge of the transfer cycle
    task automatic wait_handshake(int channel, string what);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!handshake(channel)) begin
            waited++;
            if (waited >= WAIT_LIMIT)
                abort_run($sformatf("Timeout waiting for the %s handshake", what));
            @(negedge clock);
        end
    endtask

    // Protocol assertion failures end the run too
    always @(dut0.sva0.error_count) begin
        if (dut0.sva0.error_count != 0)
            abort_run("A protocol assertion in the bound checker failed");
    end

    // ------------------------------------------------------------------------
    // Slave model

    // Channel order and completion count sampled mid-cycle
    always @(negedge clock) begin
        if (rst_n) begin
            if (wvalid && !addr_passed)
                abort_run("wvalid went high before the address handshake");
            if (bready && !data_passed)
                abort_run("bready went high before the data handshake");
            if (awvalid && awready) begin
                aw_count++;
                addr_passed = 1'b1;
            end
            if (wvalid && wready)
                data_passed = 1'b1;
            if (wr_done) begin
                done_count++;
                addr_passed = 1'b0;
                data_passed = 1'b0;
            end
        end
    end

    task automatic run_slave();
        aw_payload_t exp_aw;
        w_payload_t  exp_w;
        for (int i = 0; i < NUM_ROWS; i++) begin
            exp_aw = {rows[i].addr, rows[i].prot};
            exp_w  = {rows[i].data, rows[i].strb};
            back_off();
            awready = 1'b1;
            wait_handshake(0, "address");
            check_aw($sformatf("row %0d aw", i), exp_aw, aw);
            @(posedge clock);
            #10 awready = 1'b0;
            back_off();
            wready = 1'b1;
            wait_handshake(1, "data");
            check_w($sformatf("row %0d w", i), exp_w, w);
            @(posedge clock);
            #10 wready = 1'b0;
            back_off();
            bvalid = 1'b1;
            bresp  = rows[i].resp;
            wait_handshake(2, "response");
            @(posedge clock);
            #10 bvalid = 1'b0;
            bresp = OKAY;
        end
    endtask

    // ------------------------------------------------------------------------
    // Client

    task automatic run_client();
        int waited;
        for (int i = 0; i < NUM_ROWS; i++) begin
            waited = 0;
            @(negedge clock);
            while (!cmd_ready) begin
                waited++;
                if (waited >= WAIT_LIMIT) abort_run("Timeout waiting for cmd_ready");
                @(negedge clock);
            end
            @(posedge clock);
            #10 cmd_valid = 1'b1;
            cmd = {rows[i].addr, rows[i].prot, rows[i].data, rows[i].strb};
            @(posedge clock);
            #10 cmd_valid = 1'b0;
            // Buffer busy from the accept edge on and drops this strobe
            @(negedge clock);
            check_level($sformatf("row %0d cmd_ready after accept", i), 1'b0, cmd_ready);
            @(posedge clock);
            #10 cmd_valid = 1'b1;
            cmd = ~cmd;
            @(negedge clock);
            check_level($sformatf("row %0d cmd_ready at dropped strobe", i), 1'b0, cmd_ready);
            @(posedge clock);
            #10 cmd_valid = 1'b0;
            waited = 0;
            @(negedge clock);
            while (!wr_done) begin
                check_level($sformatf("row %0d cmd_ready busy", i), 1'b0, cmd_ready);
                waited++;
                if (waited >= WAIT_LIMIT) abort_run("Timeout waiting for wr_done");
                @(negedge clock);
            end
            check_resp($sformatf("row %0d wr_resp", i), rows[i].resp, wr_resp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        bresp      = OKAY;
        lfsr_state = 32'h78d3_9c20;
        // Zero and partial strobes and every response code
        rows[0] = {32'h0000_1000, 3'b000, 32'hdead_beef, 4'hf, OKAY};
        rows[1] = {32'h0000_1004, 3'b001, 32'h1234_5678, 4'h3, OKAY};
        rows[2] = {32'h4000_0010, 3'b010, 32'hcafe_f00d, 4'hc, SLVERR};
        rows[3] = {32'h8000_0ffc, 3'b111, 32'h0000_0000, 4'h0, OKAY};
        rows[4] = {32'hffff_fff0, 3'b100, 32'ha5a5_5a5a, 4'h1, DECERR};
        rows[5] = {32'h0000_0020, 3'b011, 32'hffff_ffff, 4'h8, EXOKAY};
        rows[6] = {32'h1234_0000, 3'b101, 32'h0f0f_f0f0, 4'h6, SLVERR};
        rows[7] = {32'h0000_0000, 3'b110, 32'h7654_3210, 4'hf, OKAY};
        repeat (10) @(posedge clock);
        #10 rst_n = 1'b1;
        @(negedge clock);
        check_level("reset cmd_ready", 1'b1, cmd_ready);
        check_level("reset awvalid", 1'b0, awvalid);
        check_level("reset wvalid", 1'b0, wvalid);
        check_level("reset bready", 1'b0, bready);
        check_level("reset wr_done", 1'b0, wr_done);
        @(posedge clock);
        #10;
        fork
            run_client();
            run_slave();
        join
        @(negedge clock);
        if (aw_count != NUM_ROWS || done_count != NUM_ROWS) begin
            abort_run($sformatf("Saw %0d address handshakes and %0d completions for %0d writes",
                                aw_count, done_count, NUM_ROWS));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule
